/* tb.f */
uartPkg.sv
byteFifo.sv
uartRx.sv
uartTx.sv
uartRegisters.sv
uartDevice.sv
uartDeviceChecks.sv
uartDeviceTb.sv

/* run.sh */
#!/bin/sh
# build and run the UART device testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module uartDeviceTb -f tb.f -o uartSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/uartSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1

/* uartDeviceTb.sv */
`timescale 1ns/1ns

module uartDeviceTb;

	localparam logic [3:0] deviceId = 4'h3;
	localparam int rxDepth = 32;
	localparam int txDepth = 32;
	localparam int runLimit = 50000;

	logic clk;
	logic rst;
	logic peripheralEnable;
	logic busWe;
	logic busOe;
	logic [15:0] busAddress;
	logic [3:0] busByteSelect;
	logic [31:0] busDataWrite;
	logic [31:0] busDataRead;
	logic busBusy;
	logic requestOutput;
	logic uartEn;
	logic serialOut;
	logic serialIn;
	logic uartIrq;
	logic forceIdle;
	logic done;
	int errors;
	int finalErrors;
	int waited;

	uartDevice #(
		.deviceId(deviceId),
		.rxDepth(rxDepth),
		.txDepth(txDepth)
	) uartDevice_i (
		.clk(clk),
		.rst(rst),
		.peripheralEnable(peripheralEnable),
		.busWe(busWe),
		.busOe(busOe),
		.busAddress(busAddress),
		.busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite),
		.busDataRead(busDataRead),
		.busBusy(busBusy),
		.requestOutput(requestOutput),
		.uartEn(uartEn),
		.uartRx(serialIn),
		.uartTx(serialOut),
		.uartIrq(uartIrq)
	);

	// serial loopback, forceIdle pins the line high
	assign serialIn = forceIdle ? 1'b1 : serialOut;

	uartDeviceChecks #(
		.deviceId(deviceId),
		.rxDepth(rxDepth),
		.txDepth(txDepth)
	) uartDeviceChecks_i (
		.clk(clk),
		.rst(rst),
		.peripheralEnable(peripheralEnable),
		.busWe(busWe),
		.busOe(busOe),
		.busAddress(busAddress),
		.busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite),
		.busDataRead(busDataRead),
		.busBusy(busBusy),
		.requestOutput(requestOutput),
		.uartIrq(uartIrq),
		.uartEn(uartEn),
		.forceIdle(forceIdle),
		.done(done),
		.errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		waited = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (done !== 1'b1 && waited < runLimit) begin
			@(negedge clk);
			waited++;
		end
		if (done !== 1'b1) begin
			$display("timeout: the checks did not finish within %0d cycles", runLimit);
			finalErrors = errors + 1;
		end else begin
			finalErrors = errors;
		end
		$display("%0d errors", finalErrors);
		if (finalErrors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

/* uartDeviceChecks.sv */
`timescale 1ns/1ns

module uartDeviceChecks #(
	parameter logic [3:0] deviceId = 4'h0,
	parameter int rxDepth = 32,
	parameter int txDepth = 32
) (
	input logic clk,
	input logic rst,
	output logic peripheralEnable,
	output logic busWe,
	output logic busOe,
	output logic [15:0] busAddress,
	output logic [3:0] busByteSelect,
	output logic [31:0] busDataWrite,
	input logic [31:0] busDataRead,
	input logic busBusy,
	input logic requestOutput,
	input logic uartIrq,
	input logic uartEn,
	output logic forceIdle,
	output logic done,
	output int errors
);
	import uartPkg::*;

	localparam int resetLimit = 20;
	localparam int busyLimit = 200;
	localparam int responseLimit = 3;
	localparam int byteLimit = 400;

	localparam logic [31:0] enableBit = 32'h1 << cfgEnable;
	localparam logic [31:0] waitBit = 32'h1 << cfgWaitForTxSpace;
	localparam logic [31:0] rxIrqBit = 32'h1 << cfgRxIrqEn;
	localparam logic [31:0] txDoneIrqBit = 32'h1 << cfgTxDoneIrqEn;
	// divisor 7 gives 8 clocks per bit
	localparam logic [31:0] baseConfig = 32'h7 | enableBit;

	localparam logic [5:0] rxOverflowStatus =
		(6'h1 << stRxAvail) | (6'h1 << stRxFull) | (6'h1 << stRxLost);
	localparam logic [5:0] txLostStatus = (6'h1 << stTxFull) | (6'h1 << stTxLost);

	// bytes sent on the line and not yet read back
	logic [7:0] model [$];
	// busBusy as first seen by the last write
	logic stalled;

	function automatic logic [15:0] addrOf(input logic [11:0] offset);
		return {deviceId, offset};
	endfunction

	task automatic reportValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, expected);
		errors++;
	endtask

	task automatic reportProblem(input string what);
		$display("error: %s", what);
		errors++;
	endtask

	task automatic busWrite(input logic [15:0] address, input logic [31:0] data,
		input logic [3:0] lanes);
		int tries;
		tries = 0;
		@(negedge clk);
		peripheralEnable = 1'b1;
		busWe = 1'b1;
		busAddress = address;
		busByteSelect = lanes;
		busDataWrite = data;
		#1;
		stalled = busBusy;
		// the DUT holds us off while its transmit FIFO is full
		while (busBusy && tries < busyLimit) begin
			@(negedge clk);
			#1;
			tries++;
		end
		if (busBusy) begin
			reportProblem("write still held by busBusy after the timeout");
		end
		@(negedge clk);
		peripheralEnable = 1'b0;
		busWe = 1'b0;
	endtask

	task automatic busRead(input logic [15:0] address, output logic [31:0] data,
		output logic ok);
		int waited;
		waited = 0;
		@(negedge clk);
		peripheralEnable = 1'b1;
		busOe = 1'b1;
		busAddress = address;
		@(negedge clk);
		ok = requestOutput;
		data = busDataRead;
		peripheralEnable = 1'b0;
		busOe = 1'b0;
		while (!ok && waited < responseLimit) begin
			@(negedge clk);
			ok = requestOutput;
			data = busDataRead;
			waited++;
		end
	endtask

	task automatic expectRead(input logic [11:0] offset, input logic [31:0] expected,
		input string name);
		logic [31:0] data;
		logic ok;
		busRead(addrOf(offset), data, ok);
		if (!ok) begin
			reportProblem({"no read response from ", name});
		end else if (data !== expected) begin
			reportValue(name, data, expected);
		end
	endtask

	task automatic waitStatus(input logic [5:0] mask, input logic [5:0] value, input int limit);
		logic [31:0] data;
		logic ok;
		int cycles;
		cycles = 0;
		busRead(addrOf(statusAddr), data, ok);
		while ((data[5:0] & mask) !== value && cycles < limit) begin
			busRead(addrOf(statusAddr), data, ok);
			cycles += 2;
		end
		if ((data[5:0] & mask) !== value) begin
			reportValue("status", data & {26'h0, mask}, {26'h0, value});
		end
	endtask

	task automatic waitIrq(input logic level, input int limit, input string what);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (uartIrq !== level && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (uartIrq !== level) begin
			reportProblem(what);
		end
	endtask

	task automatic holdIrqLow(input int cycles);
		logic seenHigh;
		seenHigh = 1'b0;
		repeat (cycles) begin
			@(negedge clk);
			if (uartIrq !== 1'b0) begin
				seenHigh = 1'b1;
			end
		end
		if (seenHigh) begin
			reportProblem("uartIrq went high with every interrupt disabled");
		end
	endtask

	task automatic setBase(input logic [31:0] extra);
		busWrite(addrOf(configAddr), baseConfig | extra, 4'hf);
	endtask

	task automatic sendByte(input logic [7:0] value);
		busWrite(addrOf(txAddr), {24'h0, value}, 4'h1);
		model.push_back(value);
	endtask

	// poll the receive register until a byte shows up
	task automatic readNextByte();
		logic [31:0] data;
		logic ok;
		logic [7:0] expected;
		int cycles;
		cycles = 0;
		busRead(addrOf(rxAddr), data, ok);
		while (!(ok && data[8]) && cycles < byteLimit) begin
			busRead(addrOf(rxAddr), data, ok);
			cycles += 2;
		end
		if (!(ok && data[8])) begin
			reportProblem("no received byte arrived before the timeout");
		end else if (model.size() == 0) begin
			reportProblem("received a byte that was never sent");
		end else begin
			expected = model.pop_front();
			if (data[7:0] !== expected) begin
				reportValue("rxByte", {24'h0, data[7:0]}, {24'h0, expected});
			end
		end
	endtask

	task automatic checkReset();
		logic [31:0] data;
		logic ok;
		expectRead(configAddr, 32'h0000_1047, "config");
		expectRead(statusAddr, 32'h0, "status");
		expectRead(clearAddr, 32'h0, "clear");
		if (uartEn !== 1'b0) begin
			reportValue("uartEn", {31'h0, uartEn}, 32'h0);
		end
		busRead({deviceId + 4'h1, configAddr}, data, ok);
		if (ok) begin
			reportProblem("a read with the wrong device ID got a response");
		end
		busRead(addrOf(12'h00c), data, ok);
		if (ok) begin
			reportProblem("a read at an unmapped offset got a response");
		end
	endtask

	task automatic checkByteLanes();
		logic [31:0] cfgModel;
		logic [31:0] data;
		logic [3:0] lanes;
		int lane;
		setBase(32'h0);
		cfgModel = baseConfig;
		repeat (16) begin
			data = $urandom;
			lanes = 4'($urandom);
			busWrite(addrOf(configAddr), data, lanes);
			for (lane = 0; lane < 4; lane++) begin
				if (lanes[lane]) begin
					cfgModel[lane * 8 +: 8] = data[lane * 8 +: 8];
				end
			end
			expectRead(configAddr, cfgModel & 32'h001f_ffff, "config");
			if (uartEn !== cfgModel[cfgEnable]) begin
				reportValue("uartEn", {31'h0, uartEn}, {31'h0, cfgModel[cfgEnable]});
			end
		end
	endtask

	task automatic checkLoopback();
		setBase(waitBit);
		repeat (20) begin
			sendByte(8'($urandom));
		end
		repeat (20) begin
			readNextByte();
		end
		expectRead(rxAddr, 32'h0, "rx");
	endtask

	task automatic checkInterrupts();
		setBase(rxIrqBit);
		if (uartIrq !== 1'b0) begin
			reportProblem("uartIrq high with an empty receive FIFO");
		end
		sendByte(8'($urandom));
		waitIrq(1'b1, 300, "receive interrupt never rose");
		readNextByte();
		waitIrq(1'b0, 10, "receive interrupt stayed high after the read");

		setBase(txDoneIrqBit);
		if (uartIrq !== 1'b0) begin
			reportProblem("uartIrq high before anything was sent");
		end
		sendByte(8'($urandom));
		waitIrq(1'b1, 40, "transmit done interrupt never rose");
		readNextByte();

		setBase(32'h0);
		sendByte(8'($urandom));
		holdIrqLow(150);
		readNextByte();
	endtask

	task automatic checkOverflow();
		int preload;
		preload = (txDepth < rxDepth + 1) ? txDepth : rxDepth + 1;
		setBase(32'h0);
		forceIdle = 1'b1;
		// load the transmit FIFO while the device is off
		busWrite(addrOf(configAddr), 32'h7 | waitBit, 4'hf);
		repeat (preload) begin
			sendByte(8'($urandom));
		end
		forceIdle = 1'b0;
		setBase(waitBit);
		repeat (rxDepth + 1 - preload) begin
			sendByte(8'($urandom));
		end
		waitStatus(6'h3f, rxOverflowStatus, (rxDepth + 2) * 100);
		repeat (rxDepth) begin
			readNextByte();
		end
		// last byte met a full FIFO
		if (model.size() != 1) begin
			reportProblem("byte model out of step after the receive overflow");
		end
		model.delete();
		expectRead(rxAddr, 32'h0, "rx");

		busWrite(addrOf(configAddr), 32'h7, 4'hf);
		repeat (40) begin
			busWrite(addrOf(txAddr), {24'h0, 8'($urandom)}, 4'h1);
		end
		waitStatus(txLostStatus, txLostStatus, 20);
	endtask

	task automatic checkClear();
		logic [31:0] clearBits;
		clearBits = (32'h1 << clrRxFifo) | (32'h1 << clrTxFifo);
		forceIdle = 1'b1;
		// enabling frees one slot, so the second write meets a full FIFO
		setBase(waitBit);
		busWrite(addrOf(txAddr), {24'h0, 8'($urandom)}, 4'h1);
		if (stalled !== 1'b0) begin
			reportValue("busBusy", {31'h0, stalled}, 32'h0);
		end
		busWrite(addrOf(txAddr), {24'h0, 8'($urandom)}, 4'h1);
		if (stalled !== 1'b1) begin
			reportValue("busBusy", {31'h0, stalled}, 32'h1);
		end
		busWrite(addrOf(clearAddr), clearBits, 4'h1);
		waitStatus(6'h3f, 6'h00, 20);
		expectRead(rxAddr, 32'h0, "rx");
		busWrite(addrOf(configAddr), 32'h7, 4'hf);
		forceIdle = 1'b0;
	endtask

	initial begin
		int waited;
		peripheralEnable = 1'b0;
		busWe = 1'b0;
		busOe = 1'b0;
		busAddress = 16'h0;
		busByteSelect = 4'h0;
		busDataWrite = 32'h0;
		forceIdle = 1'b0;
		done = 1'b0;
		errors = 0;
		stalled = 1'b0;
		waited = 0;
		void'($urandom(32'hb23));
		@(negedge clk);
		while (rst !== 1'b0 && waited < resetLimit) begin
			@(negedge clk);
			waited++;
		end
		if (rst !== 1'b0) begin
			reportProblem("reset never released");
		end
		checkReset();
		checkByteLanes();
		checkLoopback();
		checkInterrupts();
		checkOverflow();
		checkClear();
		done = 1'b1;
	end

endmodule

/* uartDevice.sv */
`timescale 1ns/1ns

module uartDevice #(
	parameter logic [3:0] deviceId = 4'h0,
	parameter int rxDepth = 32,
	parameter int txDepth = 32
) (
	input logic clk,
	input logic rst,

	input logic peripheralEnable,
	input logic busWe,
	input logic busOe,
	input logic [15:0] busAddress,
	input logic [3:0] busByteSelect,
	input logic [31:0] busDataWrite,
	output logic [31:0] busDataRead,
	output logic busBusy,
	output logic requestOutput,

	output logic uartEn,
	input logic uartRx,
	output logic uartTx,
	output logic uartIrq
);
	import uartPkg::*;

	logic [divisorWidth-1:0] cyclesPerBit;
	logic enable;
	logic waitForTxSpace;
	logic lostIrqEn;
	logic rxIrqEn;
	logic txDoneIrqEn;
	logic txPush;
	logic [7:0] txByte;
	logic rxPop;
	logic [3:0] clearPulses;

	logic [7:0] rxHead;
	logic rxAvail;
	logic rxFull;
	logic rxLost;
	logic [7:0] txHead;
	logic txAvail;
	logic txFull;
	logic txLost;

	logic [7:0] rxByte;
	logic rxValid;
	logic txBusy;
	logic txStart;
	logic rxLine;

	logic [5:0] flags;
	logic [5:0] buffered;
	logic [5:0] status;
	logic wasSending;

	uartRegisters #(.deviceId(deviceId)) uartRegisters_i (
		.clk(clk),
		.rst(rst),
		.peripheralEnable(peripheralEnable),
		.busWe(busWe),
		.busOe(busOe),
		.busAddress(busAddress),
		.busByteSelect(busByteSelect),
		.busDataWrite(busDataWrite),
		.busDataRead(busDataRead),
		.requestOutput(requestOutput),
		.busBusy(busBusy),
		.status(status),
		.rxHead(rxHead),
		.rxAvail(rxAvail),
		.txFull(txFull),
		.cyclesPerBit(cyclesPerBit),
		.enable(enable),
		.waitForTxSpace(waitForTxSpace),
		.lostIrqEn(lostIrqEn),
		.rxIrqEn(rxIrqEn),
		.txDoneIrqEn(txDoneIrqEn),
		.txPush(txPush),
		.txByte(txByte),
		.rxPop(rxPop),
		.clearPulses(clearPulses)
	);

	assign uartEn = enable;
	assign rxLine = enable ? uartRx : 1'b1;

	// one term both starts the transmitter and pops its byte
	assign txStart = txAvail && enable && !txBusy;

	byteFifo #(.depth(rxDepth)) rxFifo_i (
		.clk(clk),
		.rst(rst || clearPulses[clrRxFifo]),
		.dataIn(rxByte),
		.we(rxValid && enable),
		.oe(rxPop),
		.dataOut(rxHead),
		.isData(rxAvail),
		.bufferFull(rxFull),
		.dataLost(rxLost)
	);

	byteFifo #(.depth(txDepth)) txFifo_i (
		.clk(clk),
		.rst(rst || clearPulses[clrTxFifo]),
		.dataIn(txByte),
		.we(txPush),
		.oe(txStart),
		.dataOut(txHead),
		.isData(txAvail),
		.bufferFull(txFull),
		.dataLost(txLost)
	);

	uartRx uartRx_i (
		.clk(clk),
		.rst(rst || clearPulses[clrRx]),
		.cyclesPerBit(cyclesPerBit),
		.rx(rxLine),
		.rxByte(rxByte),
		.rxValid(rxValid)
	);

	uartTx uartTx_i (
		.clk(clk),
		.rst(rst || clearPulses[clrTx]),
		.cyclesPerBit(cyclesPerBit),
		.txStart(txStart),
		.txByteIn(txHead),
		.block(!enable),
		.tx(uartTx),
		.txBusy(txBusy)
	);

	always_comb begin
		flags = '0;
		flags[stRxAvail] = rxAvail;
		flags[stRxFull] = rxFull;
		flags[stRxLost] = rxLost;
		flags[stTxAvail] = txAvail;
		flags[stTxFull] = txFull;
		flags[stTxLost] = txLost;
	end

	// irq uses the first stage, reads see the second
	always_ff @(posedge clk) begin
		if (rst) begin
			buffered <= '0;
			status <= '0;
			wasSending <= 1'b0;
		end else begin
			buffered <= flags;
			status <= buffered;
			wasSending <= buffered[stTxAvail];
		end
	end

	assign uartIrq = (lostIrqEn && (buffered[stRxLost] || buffered[stTxLost]))
		|| (rxIrqEn && buffered[stRxAvail])
		|| (txDoneIrqEn && wasSending && !buffered[stTxAvail]);

endmodule

/* uartRegisters.sv */
`timescale 1ns/1ns

module uartRegisters #(
	parameter logic [3:0] deviceId = 4'h0
) (
	input logic clk,
	input logic rst,

	input logic peripheralEnable,
	input logic busWe,
	input logic busOe,
	input logic [15:0] busAddress,
	input logic [3:0] busByteSelect,
	input logic [31:0] busDataWrite,
	output logic [31:0] busDataRead,
	output logic requestOutput,
	output logic busBusy,

	input logic [5:0] status,
	input logic [7:0] rxHead,
	input logic rxAvail,
	input logic txFull,

	output logic [uartPkg::divisorWidth-1:0] cyclesPerBit,
	output logic enable,
	output logic waitForTxSpace,
	output logic lostIrqEn,
	output logic rxIrqEn,
	output logic txDoneIrqEn,
	output logic txPush,
	output logic [7:0] txByte,
	output logic rxPop,
	output logic [3:0] clearPulses
);
	import uartPkg::*;

	logic select;
	logic [11:0] localAddress;
	logic writeCycle;
	logic readCycle;
	logic readHit;
	logic txWrite;
	logic txStall;
	logic clearWrite;
	logic [31:0] readMux;
	logic [31:0] readData;
	logic [configWidth-1:0] configuration;

	assign select = peripheralEnable && (busAddress[15:12] == deviceId);
	assign localAddress = busAddress[11:0];
	assign writeCycle = select && busWe;
	assign readCycle = select && busOe;

	always_ff @(posedge clk) begin
		if (rst) begin
			configuration <= configDefault;
		end else if (writeCycle && localAddress == configAddr) begin
			for (int i = 0; i < configWidth; i++) begin
				if (busByteSelect[i / 8]) begin
					configuration[i] <= busDataWrite[i];
				end
			end
		end
	end

	assign cyclesPerBit = configuration[divisorWidth-1:0];
	assign waitForTxSpace = configuration[cfgWaitForTxSpace];
	assign enable = configuration[cfgEnable];
	assign lostIrqEn = configuration[cfgLostIrqEn];
	assign rxIrqEn = configuration[cfgRxIrqEn];
	assign txDoneIrqEn = configuration[cfgTxDoneIrqEn];

	// clear and transmit only act on byte lane 0
	assign clearWrite = writeCycle && localAddress == clearAddr && busByteSelect[0];
	assign clearPulses = clearWrite ? busDataWrite[3:0] : 4'b0;

	// master holds the write while the FIFO is full and we are asked to wait
	assign txWrite = writeCycle && localAddress == txAddr && busByteSelect[0];
	assign txStall = waitForTxSpace && enable && txFull;
	assign txPush = txWrite && !txStall;
	assign busBusy = txWrite && txStall;
	assign txByte = busDataWrite[7:0];

	assign rxPop = readCycle && localAddress == rxAddr && rxAvail;

	always_comb begin
		readHit = readCycle;
		case (localAddress)
			configAddr: readMux = {{(32 - configWidth){1'b0}}, configuration};
			clearAddr: readMux = 32'h0;
			statusAddr: readMux = {26'h0, status};
			rxAddr: readMux = rxAvail ? {23'h0, 1'b1, rxHead} : 32'h0;
			txAddr: readMux = 32'h0;
			default: begin
				readMux = 32'hffff_ffff;
				readHit = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			requestOutput <= 1'b0;
		end else begin
			requestOutput <= readHit;
		end
	end

	always_ff @(posedge clk) begin
		readData <= readMux;
	end

	assign busDataRead = requestOutput ? readData : 32'hffff_ffff;

	// a stalled transmit write stays on the bus until busBusy drops
	assert property (@(posedge clk) disable iff (rst) busBusy |=> txWrite);

endmodule

/* uartTx.sv */
`timescale 1ns/1ns

module uartTx (
	input logic clk,
	input logic rst,
	input logic [uartPkg::divisorWidth-1:0] cyclesPerBit,
	input logic txStart,
	input logic [7:0] txByteIn,
	input logic block,
	output logic tx,
	output logic txBusy
);
	import uartPkg::*;

	logic [9:0] shiftReg;
	logic [divisorWidth-1:0] counter;
	logic [3:0] bitCount;
	logic launch;
	logic tick;

	assign launch = txStart && !txBusy && !block;
	assign tick = counter == '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			txBusy <= 1'b0;
			counter <= '0;
			bitCount <= '0;
		end else if (block) begin
			// frame is abandoned when the device is disabled
			txBusy <= 1'b0;
		end else if (!txBusy) begin
			if (txStart) begin
				txBusy <= 1'b1;
				counter <= cyclesPerBit;
				bitCount <= '0;
			end
		end else if (tick) begin
			counter <= cyclesPerBit;
			bitCount <= bitCount + 1'b1;
			if (bitCount == 4'd9) begin
				txBusy <= 1'b0;
			end
		end else begin
			counter <= counter - 1'b1;
		end
	end

	// stop, data lsb first, start
	always_ff @(posedge clk) begin
		if (launch) begin
			shiftReg <= {1'b1, txByteIn, 1'b0};
		end else if (txBusy && tick) begin
			shiftReg <= {1'b1, shiftReg[9:1]};
		end
	end

	assign tx = (txBusy && !block) ? shiftReg[0] : 1'b1;

	assert property (@(posedge clk) disable iff (rst) txStart |-> !txBusy);

endmodule

/* uartRx.sv */
`timescale 1ns/1ns

module uartRx (
	input logic clk,
	input logic rst,
	input logic [uartPkg::divisorWidth-1:0] cyclesPerBit,
	input logic rx,
	output logic [7:0] rxByte,
	output logic rxValid
);
	import uartPkg::*;

	typedef enum logic [1:0] {
		rxIdle,
		rxStartBit,
		rxDataBits,
		rxStopBit
	} stateType;

	stateType state;
	logic rxMeta;
	logic rxSync;
	logic rxLast;
	logic [divisorWidth-1:0] counter;
	logic [2:0] bitIndex;
	logic [7:0] shiftReg;
	logic tick;

	assign tick = counter == '0;

	// two-flop synchronizer, idle level is high
	always_ff @(posedge clk) begin
		if (rst) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
			rxLast <= 1'b1;
		end else begin
			rxMeta <= rx;
			rxSync <= rxMeta;
			rxLast <= rxSync;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rxIdle;
			counter <= '0;
			bitIndex <= '0;
			rxValid <= 1'b0;
		end else begin
			rxValid <= 1'b0;
			if (state != rxIdle) begin
				counter <= tick ? cyclesPerBit : counter - 1'b1;
			end
			case (state)
				rxIdle: begin
					// half a bit to land in the middle of the start bit
					if (rxLast && !rxSync) begin
						state <= rxStartBit;
						counter <= cyclesPerBit >> 1;
					end
				end
				rxStartBit: begin
					bitIndex <= '0;
					if (tick) begin
						// line back high means a glitch, not a start bit
						state <= rxSync ? rxIdle : rxDataBits;
					end
				end
				rxDataBits: begin
					if (tick) begin
						bitIndex <= bitIndex + 1'b1;
						if (bitIndex == 3'd7) begin
							state <= rxStopBit;
						end
					end
				end
				rxStopBit: begin
					if (tick) begin
						state <= rxIdle;
						rxValid <= rxSync;
					end
				end
				default: state <= rxIdle;
			endcase
		end
	end

	// lsb arrives first
	always_ff @(posedge clk) begin
		if (state == rxDataBits && tick) begin
			shiftReg <= {rxSync, shiftReg[7:1]};
		end
		if (state == rxStopBit && tick) begin
			rxByte <= shiftReg;
		end
	end

endmodule

/* byteFifo.sv */
`timescale 1ns/1ns

module byteFifo #(
	parameter int depth = 32
) (
	input logic clk,
	input logic rst,
	input logic [7:0] dataIn,
	input logic we,
	input logic oe,
	output logic [7:0] dataOut,
	output logic isData,
	output logic bufferFull,
	output logic dataLost
);
	localparam int ptrWidth = $clog2(depth);

	logic [7:0] mem [depth];
	logic [ptrWidth-1:0] rdPtr;
	logic [ptrWidth-1:0] wrPtr;
	logic [ptrWidth:0] count;
	logic doPush;
	logic doPop;

	assign isData = count != '0;
	assign bufferFull = count == (ptrWidth + 1)'(depth);
	assign dataOut = mem[rdPtr];

	// a pop frees the slot, so push and pop together are fine when full
	assign doPush = we && (!bufferFull || oe);
	assign doPop = oe && isData;

	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= dataIn;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
			dataLost <= 1'b0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// sticky until reset or clear
			if (we && !doPush) begin
				dataLost <= 1'b1;
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst) oe |-> isData);

endmodule

/* uartPkg.sv */
package uartPkg;

	// register offsets within the 4 KiB device window
	localparam logic [11:0] configAddr = 12'h000;
	localparam logic [11:0] clearAddr = 12'h004;
	localparam logic [11:0] statusAddr = 12'h008;
	localparam logic [11:0] rxAddr = 12'h010;
	localparam logic [11:0] txAddr = 12'h014;

	// configuration register
	localparam int configWidth = 21;

	// 0x1047 is cyclesPerBit for 9600 baud from a 40 MHz clock
	localparam logic [configWidth-1:0] configDefault = 21'h01047;

	// bits 0 to 15 hold cyclesPerBit
	localparam int divisorWidth = 16;

	localparam int cfgWaitForTxSpace = 16;
	localparam int cfgEnable = 17;
	localparam int cfgLostIrqEn = 18;
	localparam int cfgRxIrqEn = 19;
	localparam int cfgTxDoneIrqEn = 20;

	// status register bits
	localparam int stRxAvail = 0;
	localparam int stRxFull = 1;
	localparam int stRxLost = 2;
	localparam int stTxAvail = 3;
	localparam int stTxFull = 4;
	localparam int stTxLost = 5;

	// clear register bits, each one resets one block
	localparam int clrRx = 0;
	localparam int clrTx = 1;
	localparam int clrRxFifo = 2;
	localparam int clrTxFifo = 3;

endpackage
